//--- filelist.f
src/digtalPkg.sv
src/strobeEdges.sv
src/ramWriter.sv
src/ramReader.sv
src/byteScheduler.sv
src/digtalMain.sv
tb/ramModel.sv
tb/digtalMainChecker.sv
tb/digtalMainTb.sv

//--- tb/digtalMainTb.sv
`timescale 1ns/10ps
`default_nettype none

module digtalMainTb;

	localparam int insertLength = 4;
	localparam logic [7:0] insertExp [0:3] = '{8'hEB, 8'h90, 8'h90, 8'hEB}; // sent in this order
	localparam int strobeHigh = 12; // full write strobe
	localparam int strobeGap = 4; // rd low between strobes
	localparam int windowHigh = 12; // cs high per byte
	localparam int windowGap = 4; // cs low between windows
	localparam int randomBytes = 40;
	localparam int drainMax = 64; // worst-case windows to empty the RAM
	localparam int totalStrobes = 3 + 1 + 1 + randomBytes;
	localparam int totalWindows = 8 + 12 + randomBytes * 3 + drainMax + insertLength;
	localparam int timeoutCycles = (totalStrobes + totalWindows) * 30 + 200;

	logic CLOCK_Digtal = 1'b0;
	logic arstN;
	logic cs;
	logic rd;
	logic [7:0] rxData;
	wire logic [7:0] outData;
	logic [7:0] ramDataIn;
	logic [30:0] ramWrAddr;
	logic ramWrEn;
	logic [30:0] ramRdAddr;
	logic ramRdEn;
	logic [7:0] ramQ;

	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int seed = 32'h7d20_cdea;
	int expWrAddr = 0; // full writes so far
	logic [7:0] expQueue [$]; // bytes written, not yet sent
	int expIdx = 0; // model insert index
	bit expReadState = 1'b0; // model serving stored bytes

	digtalMain #(
		.insertLength(insertLength)
	) UUT (
		.CLOCK_Digtal(CLOCK_Digtal),
		.arstN(arstN),
		.cs(cs),
		.rd(rd),
		.rxData(rxData),
		.outData(outData),
		.ramDataIn(ramDataIn),
		.ramWrAddr(ramWrAddr),
		.ramWrEn(ramWrEn),
		.ramRdAddr(ramRdAddr),
		.ramRdEn(ramRdEn),
		.ramQ(ramQ)
	);

	ramModel uRam (
		.CLOCK_Digtal(CLOCK_Digtal),
		.wrEn(ramWrEn),
		.wrAddr(ramWrAddr),
		.wrData(ramDataIn),
		.rdEn(ramRdEn),
		.rdAddr(ramRdAddr),
		.q(ramQ)
	);

	always #50 CLOCK_Digtal = ~CLOCK_Digtal; // 100 ns period

	always @(posedge CLOCK_Digtal) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("timeout: the run hung after %0d cycles", cycleCount);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic compareValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin // 4-state compare catches x and z
			errorCount++;
			$display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// one rd strobe while watching the RAM write port
	task automatic writeByte(input logic [7:0] value, input int highCycles);
		bit full;
		int pulses;
		int enCycles;
		logic prevEn;
		full = (highCycles >= 10); // shorter strobes are truncated
		pulses = 0;
		enCycles = 0;
		prevEn = 1'b0;
		@(posedge CLOCK_Digtal);
		rd <= 1'b1;
		rxData <= value;
		for (int i = 1; i <= highCycles + strobeGap; i++) begin
			@(negedge CLOCK_Digtal); // outputs settled
			if (ramWrEn) begin
				enCycles++;
				if (!prevEn) pulses++;
				compareValue("ramDataIn", {24'd0, ramDataIn}, {24'd0, value});
				compareValue("ramWrAddr", {1'b0, ramWrAddr}, expWrAddr);
			end
			prevEn = ramWrEn;
			@(posedge CLOCK_Digtal);
			if (i == highCycles) rd <= 1'b0;
		end
		if (full) begin
			expWrAddr++;
			expQueue.push_back(value);
		end
		compareValue("ramWrEn pulses", pulses, full ? 1 : 0);
		compareValue("ramWrEn cycles", enCycles, full ? 3 : 0);
		compareValue("ramWrAddr", {1'b0, ramWrAddr}, expWrAddr); // advanced only after a write
	endtask

	// one cs window checked against the model
	task automatic readWindow();
		logic [7:0] expByte;
		if (expReadState) expByte = expQueue.pop_front();
		else expByte = insertExp[expIdx];
		@(posedge CLOCK_Digtal);
		cs <= 1'b1;
		repeat (windowHigh - 1) @(posedge CLOCK_Digtal);
		@(negedge CLOCK_Digtal); // last high cycle
		compareValue("outData", {24'd0, outData}, {24'd0, expByte});
		@(posedge CLOCK_Digtal);
		cs <= 1'b0;
		repeat (windowGap) begin
			@(negedge CLOCK_Digtal);
			compareValue("outData", {24'd0, outData}, {24'd0, {8{1'bz}}}); // released
		end
		// scheduler rule stepped on the fall
		if (!expReadState && (expIdx != insertLength - 1)) begin
			expIdx++;
		end else begin
			expReadState = (expQueue.size() != 0);
			expIdx = 0;
		end
	endtask

	task automatic resetIdleTest();
		repeat (5) begin
			@(negedge CLOCK_Digtal);
			compareValue("ramWrEn", ramWrEn, 0);
			compareValue("ramRdEn", ramRdEn, 0);
			compareValue("ramWrAddr", {1'b0, ramWrAddr}, 0);
			compareValue("ramRdAddr", {1'b0, ramRdAddr}, 0);
			compareValue("outData", {24'd0, outData}, {24'd0, {8{1'bz}}});
		end
		repeat (8) readWindow(); // two insert blocks
	endtask

	task automatic writeAddressTest();
		writeByte(8'h11, strobeHigh);
		writeByte(8'hA7, strobeHigh);
		writeByte(8'h3C, strobeHigh);
	endtask

	task automatic shortStrobeTest();
		writeByte(8'hFF, 2); // no write, no advance
	endtask

	task automatic orderTest();
		repeat (2) readWindow();
		writeByte(8'h5A, strobeHigh); // lands mid block
		repeat (2) readWindow(); // rest of the block
		repeat (4) readWindow(); // stored bytes in write order
		repeat (insertLength) readWindow(); // block again from word 0
	endtask

	task automatic randomStreamTest();
		logic [31:0] rnd;
		for (int i = 0; i < randomBytes; i++) begin
			rnd = $random(seed);
			repeat (rnd[1:0]) readWindow(); // 0 to 3 windows
			rnd = $random(seed);
			writeByte(rnd[7:0], strobeHigh);
		end
		// model is back at word 0 once the queue is empty
		while (expQueue.size() != 0 || expReadState || expIdx != 0) begin
			readWindow();
		end
		repeat (insertLength) readWindow();
	endtask

	initial begin
		arstN = 1'b0;
		cs = 1'b0;
		rd = 1'b0;
		rxData = 8'h00;
		repeat (2) @(posedge CLOCK_Digtal);
		arstN <= 1'b1;
		resetIdleTest();
		writeAddressTest();
		shortStrobeTest();
		orderTest();
		randomStreamTest();
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/digtalMainChecker.sv
`timescale 1ns/10ps
`default_nettype none

module digtalMainChecker (
	input wire logic CLOCK_Digtal,
	input wire logic arstN,
	input wire logic cs, // raw chip select pin
	input wire logic ramWrEn,
	input wire logic [digtalPkg::addrW-1:0] ramWrAddr,
	input wire logic ramRdEn
);

	// write enable shaped by counts 2 to 4 of the write counter
	wrEnWidth: assert property (@(posedge CLOCK_Digtal) disable iff (!arstN)
		$rose(ramWrEn) |-> ramWrEn [*3] ##1 !ramWrEn)
		else $error("ramWrEn pulse is not exactly 3 cycles wide");

	wrAddrStable: assert property (@(posedge CLOCK_Digtal) disable iff (!arstN)
		(ramWrEn && $past(ramWrEn)) |-> $stable(ramWrAddr)) // pointer steps only at count 6
		else $error("ramWrAddr changed while ramWrEn was high");

	rdEnInWindow: assert property (@(posedge CLOCK_Digtal) disable iff (!arstN)
		$rose(ramRdEn) |-> cs) // reads belong to a cs window
		else $error("ramRdEn rose while cs was low");

endmodule

bind digtalMain digtalMainChecker uChecker (
	.CLOCK_Digtal(CLOCK_Digtal),
	.arstN(arstN),
	.cs(cs),
	.ramWrEn(ramWrEn),
	.ramWrAddr(ramWrAddr),
	.ramRdEn(ramRdEn)
);

`default_nettype wire

//--- tb/ramModel.sv
`timescale 1ns/10ps
`default_nettype none

module ramModel #(
	parameter int depthW = 8 // only low address bits are stored
) (
	input wire logic CLOCK_Digtal,
	input wire logic wrEn,
	input wire logic [digtalPkg::addrW-1:0] wrAddr,
	input wire logic [digtalPkg::byteW-1:0] wrData,
	input wire logic rdEn,
	input wire logic [digtalPkg::addrW-1:0] rdAddr,
	output logic [digtalPkg::byteW-1:0] q // registered read data
);

	logic [digtalPkg::byteW-1:0] mem [0:(1<<depthW)-1]; // small window onto the address space

	always_ff @(posedge CLOCK_Digtal) begin
		if (wrEn) begin
			mem[wrAddr[depthW-1:0]] <= wrData; // same byte repeated over the 3-cycle pulse
		end
		if (rdEn) begin
			q <= mem[rdAddr[depthW-1:0]]; // one cycle latency
		end
	end

endmodule

`default_nettype wire

//--- src/digtalMain.sv
`timescale 1ns/10ps
`default_nettype none

module digtalMain #(
	parameter int insertLength = 4, // words per insert block (4 to 8)
	parameter digtalPkg::insertWordsT insertWords = 64'hEB90_90EB_EB90_90EB // EB 90 90 EB ...
) (
	input wire logic CLOCK_Digtal,
	input wire logic arstN,
	input wire logic cs, // sink chip select
	input wire logic rd, // source byte strobe
	input wire logic [digtalPkg::byteW-1:0] rxData, // source byte
	output wire logic [digtalPkg::byteW-1:0] outData, // z while cs low
	output logic [digtalPkg::byteW-1:0] ramDataIn,
	output logic [digtalPkg::addrW-1:0] ramWrAddr,
	output logic ramWrEn,
	output logic [digtalPkg::addrW-1:0] ramRdAddr,
	output logic ramRdEn,
	input wire logic [digtalPkg::byteW-1:0] ramQ // registered read data
);

	digtalPkg::strobeT csEdge; // cs rise, fall, high
	digtalPkg::strobeT rdEdge; // rd rise, fall, high
	digtalPkg::ramWriteT ramWrite;
	digtalPkg::ramReadT ramRead;
	logic [digtalPkg::addrW:0] wrPtr; // full width for emptiness test
	logic readStart;
	logic [digtalPkg::byteW-1:0] readByte;
	logic readValid;
	logic dataAvail;

	strobeEdges uStrobeEdges (
		.CLOCK_Digtal(CLOCK_Digtal),
		.arstN(arstN),
		.cs(cs),
		.rd(rd),
		.csEdge(csEdge),
		.rdEdge(rdEdge)
	);

	ramWriter uRamWriter (
		.CLOCK_Digtal(CLOCK_Digtal),
		.arstN(arstN),
		.rdEdge(rdEdge),
		.rxData(rxData),
		.ramWrite(ramWrite),
		.wrPtr(wrPtr)
	);

	ramReader uRamReader (
		.CLOCK_Digtal(CLOCK_Digtal),
		.arstN(arstN),
		.readStart(readStart),
		.csHigh(csEdge.high),
		.wrPtr(wrPtr),
		.ramQ(ramQ),
		.ramRead(ramRead),
		.readByte(readByte),
		.readValid(readValid),
		.dataAvail(dataAvail)
	);

	byteScheduler #(
		.insertLength(insertLength),
		.insertWords(insertWords)
	) uByteScheduler (
		.CLOCK_Digtal(CLOCK_Digtal),
		.arstN(arstN),
		.csEdge(csEdge),
		.cs(cs),
		.dataAvail(dataAvail),
		.readByte(readByte),
		.readValid(readValid),
		.readStart(readStart),
		.outData(outData)
	);

	// RAM pins
	assign ramDataIn = ramWrite.wrData;
	assign ramWrAddr = ramWrite.wrAddr;
	assign ramWrEn = ramWrite.wrEn;
	assign ramRdAddr = ramRead.rdAddr;
	assign ramRdEn = ramRead.rdEn;

endmodule

`default_nettype wire

//--- src/byteScheduler.sv
`timescale 1ns/10ps
`default_nettype none

module byteScheduler #(
	parameter int insertLength = 4, // words per insert block (4 to 8)
	parameter digtalPkg::insertWordsT insertWords = 64'hEB90_90EB_EB90_90EB // word 0 low
) (
	input wire logic CLOCK_Digtal,
	input wire logic arstN,
	input wire digtalPkg::strobeT csEdge, // synchronized cs events
	input wire logic cs, // raw pin, drives the output enable
	input wire logic dataAvail, // stored bytes pending
	input wire logic [digtalPkg::byteW-1:0] readByte, // from reader
	input wire logic readValid, // readByte fresh
	output logic readStart, // kicks one RAM read
	output wire logic [digtalPkg::byteW-1:0] outData // tri-state to sink
);

	localparam int idxW = $clog2(digtalPkg::maxInsert);
	localparam logic [idxW-1:0] lastIdx = idxW'(insertLength - 1); // last word of block

	logic readState; // 1 serving RAM bytes, 0 sending insert words
	logic [idxW-1:0] insertIdx; // next insert word
	logic [digtalPkg::byteW-1:0] outReg; // byte shown while cs high

	assign readStart = csEdge.rise && readState; // reader does the rest

	// state steps once per window on the cs fall
	always_ff @(posedge CLOCK_Digtal or negedge arstN) begin
		if (!arstN) begin
			readState <= 1'b0;
			insertIdx <= '0;
		end else if (csEdge.fall) begin
			if (!readState && (insertIdx != lastIdx)) begin
				insertIdx <= insertIdx + 1'b1; // block not finished
			end else begin
				readState <= dataAvail; // back to word 0 when RAM empty
				insertIdx <= '0;
			end
		end
	end

	always_ff @(posedge CLOCK_Digtal or negedge arstN) begin
		if (!arstN) begin
			outReg <= '0;
		end else if (csEdge.rise && !readState) begin
			outReg <= insertWords[insertIdx]; // visible from next cycle
		end else if (readValid) begin
			outReg <= readByte; // some 6 cycles into the window
		end
	end

	assign outData = cs ? outReg : {digtalPkg::byteW{1'bz}}; // released when deselected

endmodule

`default_nettype wire

//--- src/ramReader.sv
`timescale 1ns/10ps
`default_nettype none

module ramReader (
	input wire logic CLOCK_Digtal,
	input wire logic arstN,
	input wire logic readStart, // one-cycle scheduler pulse on cs rise
	input wire logic csHigh, // synchronized cs steady high
	input wire logic [digtalPkg::addrW:0] wrPtr, // writer pointer, full width
	input wire logic [digtalPkg::byteW-1:0] ramQ, // registered RAM output
	output digtalPkg::ramReadT ramRead, // to RAM read port
	output logic [digtalPkg::byteW-1:0] readByte, // captured RAM data
	output logic readValid, // readByte updated this cycle
	output logic dataAvail // unread bytes in RAM
);

	logic rdCntEn; // read sequence armed
	logic rdLive; // sequence running inside cs window
	logic [digtalPkg::seqCountW-1:0] rdCnt; // cycles since start
	logic [digtalPkg::addrW:0] rdPtr; // same width as wrPtr

	assign rdLive = rdCntEn && csHigh; // cs low aborts the sequence

	always_ff @(posedge CLOCK_Digtal or negedge arstN) begin
		if (!arstN) begin
			rdCntEn <= 1'b0;
		end else if (readStart) begin
			rdCntEn <= 1'b1; // csHigh not yet seen at the rise
		end else if (!csHigh || (rdCnt == digtalPkg::rdAdvance)) begin
			rdCntEn <= 1'b0; // window closed or byte done
		end
	end

	always_ff @(posedge CLOCK_Digtal or negedge arstN) begin
		if (!arstN) begin
			rdCnt <= '0;
		end else if (rdLive) begin
			rdCnt <= rdCnt + 1'b1;
		end else begin
			rdCnt <= '0; // cleared whenever cs low or idle
		end
	end

	always_ff @(posedge CLOCK_Digtal or negedge arstN) begin
		if (!arstN) begin
			rdPtr <= '0;
			readValid <= 1'b0;
			readByte <= '0;
		end else begin
			readValid <= rdLive && (rdCnt == digtalPkg::rdEnLast); // one cycle pulse
			if (rdLive && (rdCnt == digtalPkg::rdEnLast)) begin
				readByte <= ramQ; // RAM had 3 cycles to answer
			end
			if (rdLive && (rdCnt == digtalPkg::rdAdvance)) begin
				rdPtr <= rdPtr + 1'b1; // byte consumed
			end
		end
	end

	assign dataAvail = (rdPtr != wrPtr); // extra bit keeps full and empty apart

	always_comb begin
		ramRead.rdEn = rdLive && (rdCnt >= digtalPkg::rdEnFirst)
			&& (rdCnt <= digtalPkg::rdEnLast); // counts 1 to 4
		ramRead.rdAddr = rdPtr[digtalPkg::addrW-1:0];
	end

endmodule

`default_nettype wire

//--- src/ramWriter.sv
`timescale 1ns/10ps
`default_nettype none

module ramWriter (
	input wire logic CLOCK_Digtal,
	input wire logic arstN,
	input wire digtalPkg::strobeT rdEdge, // synchronized rd events
	input wire logic [digtalPkg::byteW-1:0] rxData, // byte from receiver
	output digtalPkg::ramWriteT ramWrite, // to RAM write port
	output logic [digtalPkg::addrW:0] wrPtr // full width wrapping pointer
);

	logic wrCntEn; // write sequence running
	logic [digtalPkg::seqCountW-1:0] wrCnt; // cycles since enable
	logic wrPhase; // inside wrEn window

	// enable set by rise and dropped by fall or timeout
	always_ff @(posedge CLOCK_Digtal or negedge arstN) begin
		if (!arstN) begin
			wrCntEn <= 1'b0;
		end else if (rdEdge.rise) begin
			wrCntEn <= 1'b1; // new byte on rxData
		end else if (rdEdge.fall || (wrCnt > digtalPkg::writeDelay)) begin
			wrCntEn <= 1'b0; // strobe ended or rd stuck high
		end
	end

	always_ff @(posedge CLOCK_Digtal or negedge arstN) begin
		if (!arstN) begin
			wrCnt <= '0;
		end else if (wrCntEn) begin
			wrCnt <= wrCnt + 1'b1;
		end else begin
			wrCnt <= '0; // idle until next rise
		end
	end

	// gated by enable so an early fall suppresses the write
	assign wrPhase = wrCntEn && (wrCnt >= digtalPkg::wrEnFirst)
		&& (wrCnt <= digtalPkg::wrEnLast);

	always_ff @(posedge CLOCK_Digtal or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
		end else if (wrCntEn && (wrCnt == digtalPkg::wrAdvance)) begin
			wrPtr <= wrPtr + 1'b1; // after wrEn has closed
		end
	end

	always_comb begin
		ramWrite.wrEn = wrPhase; // 3 cycles at counts 2 to 4
		ramWrite.wrAddr = wrPtr[digtalPkg::addrW-1:0]; // drop wrap bit
		ramWrite.wrData = rxData; // held by source while rd high
	end

endmodule

`default_nettype wire

//--- src/strobeEdges.sv
`timescale 1ns/10ps
`default_nettype none

module strobeEdges (
	input wire logic CLOCK_Digtal,
	input wire logic arstN,
	input wire logic cs, // async chip select pin
	input wire logic rd, // async receiver data strobe pin
	output digtalPkg::strobeT csEdge, // cs events in clock domain
	output digtalPkg::strobeT rdEdge // rd events in clock domain
);

	logic [1:0] csHist; // bit 1 older sample
	logic [1:0] rdHist; // bit 1 older sample

	// same edge decode for both inputs
	function automatic digtalPkg::strobeT decodeHist(input logic [1:0] hist);
		digtalPkg::strobeT ev;
		ev.rise = (hist == 2'b01); // was low, now high
		ev.fall = (hist == 2'b10); // was high, now low
		ev.high = (hist == 2'b11); // steady high
		return ev;
	endfunction

	always_ff @(posedge CLOCK_Digtal or negedge arstN) begin
		if (!arstN) begin
			csHist <= 2'b00;
			rdHist <= 2'b00;
		end else begin
			csHist <= {csHist[0], cs}; // shift in new sample
			rdHist <= {rdHist[0], rd};
		end
	end

	assign csEdge = decodeHist(csHist);
	assign rdEdge = decodeHist(rdHist);

endmodule

`default_nettype wire

//--- src/digtalPkg.sv
`default_nettype none

package digtalPkg;

	localparam int byteW = 8; // data byte
	localparam int addrW = 31; // RAM port address width

	// write sequence counted from the synchronized rd rise
	localparam int writeDelay = 15; // write counter stops beyond this
	localparam int seqCountW = 8; // both sequence counters
	localparam int wrEnFirst = 2; // first count with wrEn high
	localparam int wrEnLast = 4; // last count with wrEn high
	localparam int wrAdvance = 6; // write pointer step

	// read sequence counted from readStart
	localparam int rdEnFirst = 1; // first count with rdEn high
	localparam int rdEnLast = 4; // last rdEn count and ramQ sample
	localparam int rdAdvance = 6; // read pointer step and counter stop

	localparam int maxInsert = 8; // insert table capacity

	typedef logic [maxInsert-1:0][byteW-1:0] insertWordsT; // word 0 in low byte goes first

	typedef struct packed {
		logic rise; // history old low, new high
		logic fall; // history old high, new low
		logic high; // both samples high
	} strobeT;

	typedef struct packed {
		logic wrEn;
		logic [addrW-1:0] wrAddr;
		logic [byteW-1:0] wrData;
	} ramWriteT;

	typedef struct packed {
		logic rdEn;
		logic [addrW-1:0] rdAddr;
	} ramReadT;

endpackage

`default_nettype wire
